// File: Bender.yml
package:
  name: mips_exec

sources:
  - mips_pkg.sv
  - exec_if.sv
  - reg_file.sv
  - alu.sv
  - instr_decode.sv
  - exec_stage.sv
  - mips_exec_top.sv
  - target: test
    files:
      - tb_mips_exec.sv

// File: alu.sv
`timescale 1ns/100ps

module alu import mips_pkg::*; (
	input  logic [31:0]         alu_num1,
	input  logic [31:0]         alu_num2,
	input  logic [4:0]          sa,
	input  logic [ALU_OP_W-1:0] alucontrol,
	output logic [31:0]         alu_out,
	output logic                overflow,
	output logic                zero
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        add_ovf;
	logic        sub_ovf;

	assign sum  = alu_num1 + alu_num2;
	assign diff = alu_num1 - alu_num2;

	// same-sign operands, result sign flips
	assign add_ovf = (alu_num1[31] == alu_num2[31]) && (sum[31] != alu_num1[31]);
	// opposite-sign operands, result takes the subtrahend's sign
	assign sub_ovf = (alu_num1[31] != alu_num2[31]) && (diff[31] != alu_num1[31]);

	always_comb begin
		overflow = 1'b0;
		case (alucontrol)
			// logic
			ALU_AND:   alu_out = alu_num1 & alu_num2;
			ALU_OR:    alu_out = alu_num1 | alu_num2;
			ALU_XOR:   alu_out = alu_num1 ^ alu_num2;
			ALU_NOR:   alu_out = ~(alu_num1 | alu_num2);
			// logic immediate, upper half forced to zero
			ALU_ANDI:  alu_out = alu_num1 & {16'b0, alu_num2[15:0]};
			ALU_ORI:   alu_out = alu_num1 | {16'b0, alu_num2[15:0]};
			ALU_XORI:  alu_out = alu_num1 ^ {16'b0, alu_num2[15:0]};
			ALU_LUI:   alu_out = {alu_num2[15:0], 16'b0};
			// shifts act on rt, amount from shamt or rs[4:0]
			ALU_SLL:   alu_out = alu_num2 << sa;
			ALU_SRL:   alu_out = alu_num2 >> sa;
			ALU_SRA:   alu_out = $signed(alu_num2) >>> sa;
			ALU_SLLV:  alu_out = alu_num2 << alu_num1[4:0];
			ALU_SRLV:  alu_out = alu_num2 >> alu_num1[4:0];
			ALU_SRAV:  alu_out = $signed(alu_num2) >>> alu_num1[4:0];
			// arithmetic
			ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: begin
				alu_out  = sum;
				overflow = add_ovf;
			end
			ALU_SUB, ALU_SUBU: begin
				alu_out  = diff;
				overflow = sub_ovf;
			end
			// set on less than
			ALU_SLT, ALU_SLTI: begin
				alu_out = {31'b0, $signed(alu_num1) < $signed(alu_num2)};
			end
			ALU_SLTU, ALU_SLTIU: begin
				alu_out = {31'b0, alu_num1 < alu_num2};
			end
			// branch compare, zero means equal
			ALU_BEQ, ALU_BNE: alu_out = diff;
			default:          alu_out = '0;
		endcase
	end

	assign zero = (alu_out == '0);

endmodule

// File: exec_if.sv
`timescale 1ns/100ps

interface exec_if import mips_pkg::*; ();

	// decoded operation, registered in the decoder
	logic                valid;
	logic [ALU_OP_W-1:0] alu_op;
	logic [31:0]         num1;
	logic [31:0]         num2;
	logic [4:0]          sa;
	logic [4:0]          dest;
	// low for branches
	logic                wr_en;
	// only add, sub and addi trap
	logic                trap_ovf;

	// bypass of the result in the execute stage
	logic                fwd_en;
	logic [4:0]          fwd_addr;
	logic [31:0]         fwd_data;

	modport dec (
		output valid, alu_op, num1, num2, sa, dest, wr_en, trap_ovf,
		input  fwd_en, fwd_addr, fwd_data
	);

	modport exe (
		input  valid, alu_op, num1, num2, sa, dest, wr_en, trap_ovf,
		output fwd_en, fwd_addr, fwd_data
	);

endinterface

// File: exec_stage.sv
`timescale 1ns/100ps

module exec_stage import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	exec_if.exe         ex,
	output logic        wb_valid,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data,
	output logic        branch_valid,
	output logic        branch_taken,
	output logic        overflow
);

	logic [31:0] alu_out;
	logic        alu_ovf;
	logic        alu_zero;
	logic        is_branch;
	logic        trap_hit;
	logic        do_wb;

	alu i_alu (
		.alu_num1   (ex.num1),
		.alu_num2   (ex.num2),
		.sa         (ex.sa),
		.alucontrol (ex.alu_op),
		.alu_out    (alu_out),
		.overflow   (alu_ovf),
		.zero       (alu_zero)
	);

	assign is_branch = (ex.alu_op == ALU_BEQ) || (ex.alu_op == ALU_BNE);
	// trapping op that overflowed, write is cancelled
	assign trap_hit  = ex.valid && ex.trap_ovf && alu_ovf;
	assign do_wb     = ex.valid && ex.wr_en && (ex.dest != REG_ZERO) && !trap_hit;

	// result of the op held now, for the decoder bypass
	assign ex.fwd_en   = do_wb;
	assign ex.fwd_addr = ex.dest;
	assign ex.fwd_data = alu_out;

	// strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid     <= 1'b0;
			branch_valid <= 1'b0;
			overflow     <= 1'b0;
		end else begin
			wb_valid     <= do_wb;
			branch_valid <= ex.valid && is_branch;
			overflow     <= trap_hit;
		end
	end

	// payload behind the strobes
	always_ff @(posedge clk) begin
		wb_addr      <= ex.dest;
		wb_data      <= alu_out;
		branch_taken <= (ex.alu_op == ALU_BEQ) ? alu_zero : !alu_zero;
	end

endmodule

// File: flist.f
mips_pkg.sv
exec_if.sv
reg_file.sv
alu.sv
instr_decode.sv
exec_stage.sv
mips_exec_top.sv
tb_mips_exec.sv

// File: golden_vectors.txt
// columns: instr kind reg data taken
// kind 0 none, 1 write-back, 2 branch, 3 overflow
3c011234 1 01 12340000 0 // lui r1, 0x1234
34215678 1 01 12345678 0 // ori r1, r1, 0x5678 (bypass)
3c02f0f0 1 02 f0f00000 0 // lui r2, 0xf0f0
344200ff 1 02 f0f000ff 0 // ori r2, r2, 0x00ff
00221824 1 03 10300078 0 // and r3, r1, r2
00222025 1 04 f2f456ff 0 // or r4, r1, r2
00222826 1 05 e2c45687 0 // xor r5, r1, r2
00223027 1 06 0d0ba900 0 // nor r6, r1, r2
3047ffff 1 07 000000ff 0 // andi r7, r2, 0xffff
38288001 1 08 1234d679 0 // xori r8, r1, 0x8001
00024900 1 09 0f000ff0 0 // sll r9, r2, 4
00025202 1 0a 00f0f000 0 // srl r10, r2, 8
00025a03 1 0b fff0f000 0 // sra r11, r2, 8
240c0004 1 0c 00000004 0 // addiu r12, r0, 4
01826804 1 0d 0f000ff0 0 // sllv r13, r2, r12
01827006 1 0e 0f0f000f 0 // srlv r14, r2, r12
01827807 1 0f ff0f000f 0 // srav r15, r2, r12
3c107fff 1 10 7fff0000 0 // lui r16, 0x7fff
3610ffff 1 10 7fffffff 0 // ori r16, r16, 0xffff
24110001 1 11 00000001 0 // addiu r17, r0, 1
24120055 1 12 00000055 0 // addiu r18, r0, 0x55
02119020 3 12 00000000 0 // add r18, r16, r17 traps
02119821 1 13 80000000 0 // addu r19, r16, r17 wraps
0011a023 1 14 ffffffff 0 // subu r20, r0, r17
0240a825 1 15 00000055 0 // or r21, r18, r0 keeps old r18
0291b02a 1 16 00000001 0 // slt r22, r20, r17
0291b82b 1 17 00000000 0 // sltu r23, r20, r17
2a980000 1 18 00000001 0 // slti r24, r20, 0
2e39ffff 1 19 00000001 0 // sltiu r25, r17, 0xffff
223afffe 1 1a ffffffff 0 // addi r26, r17, -2
112d0000 2 00 00000000 1 // beq r9, r13 equal
152d0000 2 00 00000000 0 // bne r9, r13 equal
10220000 2 00 00000000 0 // beq r1, r2 unequal
14220000 2 00 00000000 1 // bne r1, r2 unequal
24001234 0 00 00000000 0 // addiu r0, r0, 0x1234 discarded
0000d825 1 1b 00000000 0 // or r27, r0, r0
fc000000 0 00 00000000 0 // unknown opcode, dropped

// File: instr_decode.sv
`timescale 1ns/100ps

module instr_decode import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  instr_u      instr,
	output logic [4:0]  rs_addr,
	output logic [4:0]  rt_addr,
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	exec_if.dec         ex
);

	logic [31:0]         rs_val;
	logic [31:0]         rt_val;
	logic [31:0]         imm_sext;
	logic [31:0]         imm_raw;
	logic                known;
	logic [ALU_OP_W-1:0] op_d;
	logic [31:0]         num2_d;
	logic [4:0]          dest_d;
	logic                wr_en_d;
	logic                trap_d;

	// source fields sit in the same place for both formats
	assign rs_addr = instr.r.rs;
	assign rt_addr = instr.r.rt;

	// bypass from the instruction one ahead
	// older results already come through the register file
	assign rs_val = (ex.fwd_en && (rs_addr != REG_ZERO) && (ex.fwd_addr == rs_addr)) ?
		ex.fwd_data : rs_data;
	assign rt_val = (ex.fwd_en && (rt_addr != REG_ZERO) && (ex.fwd_addr == rt_addr)) ?
		ex.fwd_data : rt_data;

	assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
	// alu zero-extends logical immediates itself
	assign imm_raw  = {16'b0, instr.i.imm};

	always_comb begin
		known   = 1'b1;
		op_d    = ALU_ADDU;
		num2_d  = rt_val;
		dest_d  = instr.i.rt;
		wr_en_d = 1'b1;
		trap_d  = 1'b0;
		case (instr.r.opcode)
			OP_SPECIAL: begin
				// r-type writes rd
				dest_d = instr.r.rd;
				case (instr.r.funct)
					FN_SLL:  op_d = ALU_SLL;
					FN_SRL:  op_d = ALU_SRL;
					FN_SRA:  op_d = ALU_SRA;
					FN_SLLV: op_d = ALU_SLLV;
					FN_SRLV: op_d = ALU_SRLV;
					FN_SRAV: op_d = ALU_SRAV;
					FN_ADD: begin
						op_d   = ALU_ADD;
						trap_d = 1'b1;
					end
					FN_ADDU: op_d = ALU_ADDU;
					FN_SUB: begin
						op_d   = ALU_SUB;
						trap_d = 1'b1;
					end
					FN_SUBU: op_d = ALU_SUBU;
					FN_AND:  op_d = ALU_AND;
					FN_OR:   op_d = ALU_OR;
					FN_XOR:  op_d = ALU_XOR;
					FN_NOR:  op_d = ALU_NOR;
					FN_SLT:  op_d = ALU_SLT;
					FN_SLTU: op_d = ALU_SLTU;
					// unknown funct, drop
					default: known = 1'b0;
				endcase
			end
			OP_ADDI: begin
				op_d   = ALU_ADDI;
				num2_d = imm_sext;
				trap_d = 1'b1;
			end
			OP_ADDIU: begin
				op_d   = ALU_ADDIU;
				num2_d = imm_sext;
			end
			OP_SLTI: begin
				op_d   = ALU_SLTI;
				num2_d = imm_sext;
			end
			OP_SLTIU: begin
				// sign-extended, then compared unsigned
				op_d   = ALU_SLTIU;
				num2_d = imm_sext;
			end
			OP_ANDI: begin
				op_d   = ALU_ANDI;
				num2_d = imm_raw;
			end
			OP_ORI: begin
				op_d   = ALU_ORI;
				num2_d = imm_raw;
			end
			OP_XORI: begin
				op_d   = ALU_XORI;
				num2_d = imm_raw;
			end
			OP_LUI: begin
				op_d   = ALU_LUI;
				num2_d = imm_raw;
			end
			// compare only, no register write
			OP_BEQ: begin
				op_d    = ALU_BEQ;
				wr_en_d = 1'b0;
			end
			OP_BNE: begin
				op_d    = ALU_BNE;
				wr_en_d = 1'b0;
			end
			default: known = 1'b0;
		endcase
	end

	// control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= instr_valid && known;
		end
	end

	// payload, qualified by valid
	always_ff @(posedge clk) begin
		ex.alu_op   <= op_d;
		ex.num1     <= rs_val;
		ex.num2     <= num2_d;
		ex.sa       <= instr.r.shamt;
		ex.dest     <= dest_d;
		ex.wr_en    <= wr_en_d;
		ex.trap_ovf <= trap_d;
	end

endmodule

// File: mips_exec_top.sv
`timescale 1ns/100ps

module mips_exec_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	output logic        wb_valid,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data,
	output logic        branch_valid,
	output logic        branch_taken,
	output logic        overflow
);

	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;

	// decoder to execute, bypass flows back
	exec_if ex_bus ();

	// write port fed by the registered write-back
	reg_file i_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb_valid),
		.wa      (wb_addr),
		.wd      (wb_data)
	);

	instr_decode i_instr_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.ex          (ex_bus.dec)
	);

	exec_stage i_exec_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex           (ex_bus.exe),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.branch_valid (branch_valid),
		.branch_taken (branch_taken),
		.overflow     (overflow)
	);

endmodule

// File: mips_pkg.sv
package mips_pkg;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// funct field of SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// alu operation codes, one per alu case
	localparam int ALU_OP_W = 8;
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 8'b00100100;
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 8'b00100101;
	localparam logic [ALU_OP_W-1:0] ALU_XOR   = 8'b00100110;
	localparam logic [ALU_OP_W-1:0] ALU_NOR   = 8'b00100111;
	localparam logic [ALU_OP_W-1:0] ALU_ANDI  = 8'b01011001;
	localparam logic [ALU_OP_W-1:0] ALU_ORI   = 8'b01011010;
	localparam logic [ALU_OP_W-1:0] ALU_XORI  = 8'b01011011;
	localparam logic [ALU_OP_W-1:0] ALU_LUI   = 8'b01011100;
	localparam logic [ALU_OP_W-1:0] ALU_SLL   = 8'b01111100;
	localparam logic [ALU_OP_W-1:0] ALU_SRL   = 8'b00000010;
	localparam logic [ALU_OP_W-1:0] ALU_SRA   = 8'b00000011;
	localparam logic [ALU_OP_W-1:0] ALU_SLLV  = 8'b00000100;
	localparam logic [ALU_OP_W-1:0] ALU_SRLV  = 8'b00000110;
	localparam logic [ALU_OP_W-1:0] ALU_SRAV  = 8'b00000111;
	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 8'b00100000;
	localparam logic [ALU_OP_W-1:0] ALU_ADDU  = 8'b00100001;
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 8'b00100010;
	localparam logic [ALU_OP_W-1:0] ALU_SUBU  = 8'b00100011;
	localparam logic [ALU_OP_W-1:0] ALU_SLT   = 8'b00101010;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 8'b00101011;
	localparam logic [ALU_OP_W-1:0] ALU_ADDI  = 8'b01010101;
	localparam logic [ALU_OP_W-1:0] ALU_ADDIU = 8'b01010110;
	localparam logic [ALU_OP_W-1:0] ALU_SLTI  = 8'b01010111;
	localparam logic [ALU_OP_W-1:0] ALU_SLTIU = 8'b01011000;
	localparam logic [ALU_OP_W-1:0] ALU_BEQ   = 8'b01010001;
	localparam logic [ALU_OP_W-1:0] ALU_BNE   = 8'b01010010;

	// register 0 is hardwired to zero
	localparam logic [4:0] REG_ZERO = 5'd0;

	// one instruction word, seen as r-type or i-type
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instr_u;

endpackage

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd
);

	logic [31:0] regs [32];
	logic        wr_live;

	// a write to r0 never lands
	assign wr_live = we && (wa != REG_ZERO);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	// read port rs
	// write data bypasses the array in the same cycle
	always_comb begin
		if (rs_addr == REG_ZERO) begin
			rs_data = '0;
		end else if (wr_live && (wa == rs_addr)) begin
			rs_data = wd;
		end else begin
			rs_data = regs[rs_addr];
		end
	end

	// read port rt, same rules
	always_comb begin
		if (rt_addr == REG_ZERO) begin
			rt_data = '0;
		end else if (wr_live && (wa == rt_addr)) begin
			rt_data = wd;
		end else begin
			rt_data = regs[rt_addr];
		end
	end

endmodule

// File: tb_mips_exec.sv
`timescale 1ns/100ps

module tb_mips_exec;

	// result kinds in the golden file
	localparam logic [1:0] KIND_NONE   = 2'd0;
	localparam logic [1:0] KIND_WB     = 2'd1;
	localparam logic [1:0] KIND_BRANCH = 2'd2;
	localparam logic [1:0] KIND_OVF    = 2'd3;
	// instr, kind, reg, data, taken
	localparam int COLS         = 5;
	localparam int MAX_VECS     = 256;
	localparam int RESET_CYCLES = 16;
	// falling edges from the drive edge to the check that sees the result
	localparam int RESULT_DELAY = 3;

	typedef struct packed {
		logic [31:0] instr;
		logic [1:0]  kind;
		logic [4:0]  reg_num;
		logic [31:0] data;
		logic        taken;
		logic [31:0] due;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        branch_valid;
	logic        branch_taken;
	logic        overflow;

	logic [31:0] golden_mem [0:COLS*MAX_VECS-1];
	// results still owed by the DUT in issue order
	expect_t     expect_q [$];
	int          num_vecs;
	int          errors;
	int          cycles;
	int          cycle_limit;
	int          negedges;

	mips_exec_top i_mips_exec_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.branch_valid (branch_valid),
		.branch_taken (branch_taken),
		.overflow     (overflow)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// entries never loaded stay x
	function automatic int count_vectors();
		int n;
		n = 0;
		while ((n < MAX_VECS) && (golden_mem[COLS*n] !== 32'bx)) begin
			n++;
		end
		return n;
	endfunction

	task automatic note_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp, input logic [31:0] word);
		if (got !== exp) begin
			errors++;
			$display("ERROR t=%0t %s: got %h expected %h (instr %h)",
				$time, name, got, exp, word);
		end
	endtask

	// one vector onto the inputs and its result into the queue
	task automatic drive_vector(input int idx);
		expect_t e;
		e.instr   = golden_mem[COLS*idx];
		e.kind    = golden_mem[COLS*idx+1][1:0];
		e.reg_num = golden_mem[COLS*idx+2][4:0];
		e.data    = golden_mem[COLS*idx+3];
		e.taken   = golden_mem[COLS*idx+4][0];
		e.due     = negedges + RESULT_DELAY;
		instr_valid <= 1'b1;
		instr       <= e.instr;
		if (golden_mem[COLS*idx+1] > KIND_OVF) begin
			note_failure($sformatf("bad kind %h in golden file for %h",
				golden_mem[COLS*idx+1], e.instr));
		end else if (e.kind != KIND_NONE) begin
			expect_q.push_back(e);
		end
	endtask

	task automatic check_result();
		expect_t e;
		int      strobes;
		strobes = 0;
		if (wb_valid) strobes++;
		if (branch_valid) strobes++;
		if (overflow) strobes++;
		if (strobes > 1) begin
			note_failure("more than one result strobe in the same cycle");
		end else if (strobes == 1) begin
			if (expect_q.size() == 0) begin
				note_failure("result strobe while no instruction was outstanding");
			end else begin
				e = expect_q.pop_front();
				if (negedges != e.due) begin
					note_failure($sformatf("instr %h gave its result at cycle %0d instead of %0d",
						e.instr, negedges, e.due));
				end
				case (e.kind)
					KIND_WB: begin
						if (!wb_valid) begin
							note_failure($sformatf("instr %h gave no write-back", e.instr));
						end else begin
							compare_word("wb_addr", {27'b0, wb_addr}, {27'b0, e.reg_num}, e.instr);
							compare_word("wb_data", wb_data, e.data, e.instr);
						end
					end
					KIND_BRANCH: begin
						if (!branch_valid) begin
							note_failure($sformatf("instr %h gave no branch result", e.instr));
						end else begin
							compare_word("branch_taken", {31'b0, branch_taken}, {31'b0, e.taken},
								e.instr);
						end
					end
					// the only kind left in the queue is overflow
					default: begin
						if (!overflow) begin
							note_failure($sformatf("instr %h did not trap on overflow", e.instr));
						end
					end
				endcase
			end
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		negedges++;
		if (rst_n === 1'b1) begin
			check_result();
		end
	end

	// watchdog with a limit set once the vectors are counted
	initial begin
		cycles = 0;
		@(posedge clk);
		cycles = 1;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d results never seen and %0d errors",
			cycles, expect_q.size(), errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		errors      = 0;
		negedges    = 0;
		$readmemh("golden_vectors.txt", golden_mem);
		num_vecs    = count_vectors();
		cycle_limit = RESET_CYCLES + num_vecs + 20;
		if (num_vecs == 0) begin
			note_failure("no vectors found in golden_vectors.txt");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// back to back so the bypass gets used
		for (int i = 0; i < num_vecs; i++) begin
			@(posedge clk);
			drive_vector(i);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		instr       <= '0;
		// wait for every queued result
		while (expect_q.size() > 0) begin
			@(posedge clk);
		end
		// catch stray strobes behind the last result
		repeat (3) @(posedge clk);
		$display("%0d vectors run, %0d errors", num_vecs, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
